// File: source/ooo_pkg.sv
package ooo_pkg;

  localparam int XLEN = 32;
  localparam int REG_COUNT = 16;
  localparam int REG_BITS = 4;
  localparam int STATION_SIZE = 8;
  localparam int INDEX_BITS = 3;
  localparam int TAG_BITS = 4;      // unit bit, then entry index.
  localparam int IMM_BITS = 16;
  localparam int MUL_LATENCY = 3;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ADDI,                        // imm replaces second operand.
    OP_MUL
  } op_e;

  typedef enum logic [0:0] {
    UNIT_ALU = 1'b0,
    UNIT_MUL = 1'b1
  } unit_e;

endpackage

// File: source/register_status.sv
`timescale 1ns/1ns

module register_status (
  input  logic                                 global_bus,
  input  logic                                 rst_n,
  input  logic [ooo_pkg::REG_BITS-1:0]         rs1,
  input  logic [ooo_pkg::REG_BITS-1:0]         rs2,
  output logic [ooo_pkg::XLEN-1:0]             rs1_value,
  output logic [ooo_pkg::XLEN-1:0]             rs2_value,
  output logic                                 rs1_ready,
  output logic                                 rs2_ready,
  output logic [ooo_pkg::TAG_BITS-1:0]         rs1_tag,
  output logic [ooo_pkg::TAG_BITS-1:0]         rs2_tag,
  input  logic                                 rename,
  input  logic [ooo_pkg::REG_BITS-1:0]         rename_rd,
  input  logic [ooo_pkg::TAG_BITS-1:0]         rename_tag,
  input  logic [1:0]                           cdb_valid,
  input  logic [1:0][ooo_pkg::TAG_BITS-1:0]    cdb_tag,
  input  logic [1:0][ooo_pkg::XLEN-1:0]        cdb_value,
  input  logic [ooo_pkg::REG_BITS-1:0]         reg_read_addr,
  output logic [ooo_pkg::XLEN-1:0]             reg_read_data,
  output logic                                 any_busy
);
  import ooo_pkg::*;

  logic [XLEN-1:0]      value [REG_COUNT];
  logic [TAG_BITS-1:0]  producer [REG_COUNT];
  logic [REG_COUNT-1:0] busy;

  always_comb begin
    rs1_value = value[rs1];
    rs1_ready = !busy[rs1];
    rs1_tag   = producer[rs1];
    rs2_value = value[rs2];
    rs2_ready = !busy[rs2];
    rs2_tag   = producer[rs2];
    // result on a bus this cycle counts as ready.
    for (int k = 0; k < 2; k++) begin
      if (busy[rs1] && cdb_valid[k] && cdb_tag[k] == producer[rs1]) begin
        rs1_value = cdb_value[k];
        rs1_ready = 1'b1;
      end
      if (busy[rs2] && cdb_valid[k] && cdb_tag[k] == producer[rs2]) begin
        rs2_value = cdb_value[k];
        rs2_ready = 1'b1;
      end
    end
  end

  always_ff @(posedge global_bus or negedge rst_n) begin
    if (!rst_n) begin
      busy <= '0;
      for (int r = 0; r < REG_COUNT; r++) begin
        value[r]    <= '0;
        producer[r] <= '0;
      end
    end else begin
      for (int r = 0; r < REG_COUNT; r++) begin
        for (int k = 0; k < 2; k++) begin
          if (busy[r] && cdb_valid[k] && cdb_tag[k] == producer[r]) begin
            value[r] <= cdb_value[k];
            busy[r]  <= 1'b0;
          end
        end
      end
      if (rename) begin             // wins over a same-edge write-back.
        busy[rename_rd]     <= 1'b1;
        producer[rename_rd] <= rename_tag;
      end
    end
  end

  assign reg_read_data = value[reg_read_addr];
  assign any_busy = |busy;

endmodule

// File: source/issue_unit.sv
`timescale 1ns/1ns

module issue_unit (
  input  logic                                 global_bus,
  input  logic                                 rst_n,
  input  logic                                 instr_valid,
  input  ooo_pkg::op_e                         instr_op,
  input  logic [ooo_pkg::REG_BITS-1:0]         instr_rd,
  input  logic [ooo_pkg::REG_BITS-1:0]         instr_rs1,
  input  logic [ooo_pkg::REG_BITS-1:0]         instr_rs2,
  input  logic [ooo_pkg::IMM_BITS-1:0]         instr_imm,
  output logic                                 instr_ready,
  output logic                                 idle,
  input  logic                                 any_busy,
  output logic [ooo_pkg::REG_BITS-1:0]         rs1,
  output logic [ooo_pkg::REG_BITS-1:0]         rs2,
  input  logic [ooo_pkg::XLEN-1:0]             rs1_value,
  input  logic [ooo_pkg::XLEN-1:0]             rs2_value,
  input  logic                                 rs1_ready,
  input  logic                                 rs2_ready,
  input  logic [ooo_pkg::TAG_BITS-1:0]         rs1_tag,
  input  logic [ooo_pkg::TAG_BITS-1:0]         rs2_tag,
  output logic                                 rename,
  output logic [ooo_pkg::REG_BITS-1:0]         rename_rd,
  output logic [ooo_pkg::TAG_BITS-1:0]         rename_tag,
  input  logic [1:0][ooo_pkg::INDEX_BITS-1:0]  free_index,
  input  logic [1:0]                           credit_return,
  output logic [1:0]                           alloc,
  output ooo_pkg::op_e                         alloc_op,
  output logic [ooo_pkg::XLEN-1:0]             alloc_a,
  output logic [ooo_pkg::XLEN-1:0]             alloc_b,
  output logic                                 alloc_a_ready,
  output logic                                 alloc_b_ready,
  output logic [ooo_pkg::TAG_BITS-1:0]         alloc_a_tag,
  output logic [ooo_pkg::TAG_BITS-1:0]         alloc_b_tag
);
  import ooo_pkg::*;

  function automatic unit_e unit_of(input op_e op);
    return (op == OP_MUL) ? UNIT_MUL : UNIT_ALU;
  endfunction

  logic [1:0][INDEX_BITS:0] credits;
  unit_e target;
  logic accept;
  logic is_imm;

  assign target = unit_of(instr_op);
  assign instr_ready = credits[target] != '0;
  assign accept = instr_valid && instr_ready;
  assign is_imm = instr_op == OP_ADDI;
  assign idle = credits[0] == STATION_SIZE && credits[1] == STATION_SIZE && !any_busy;

  assign alloc[UNIT_ALU] = accept && target == UNIT_ALU;
  assign alloc[UNIT_MUL] = accept && target == UNIT_MUL;

  always_ff @(posedge global_bus or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < 2; k++) begin
        credits[k] <= (INDEX_BITS + 1)'(STATION_SIZE);
      end
    end else begin
      for (int k = 0; k < 2; k++) begin
        credits[k] <= credits[k] + (INDEX_BITS + 1)'(credit_return[k])
                                 - (INDEX_BITS + 1)'(alloc[k]);
      end
    end
  end

  assign rs1 = instr_rs1;
  assign rs2 = instr_rs2;

  assign rename     = accept;
  assign rename_rd  = instr_rd;
  assign rename_tag = {target, free_index[target]};   // station, then entry.

  assign alloc_op      = instr_op;
  assign alloc_a       = rs1_value;
  assign alloc_a_ready = rs1_ready;
  assign alloc_a_tag   = rs1_tag;
  assign alloc_b       = is_imm ? {{(XLEN - IMM_BITS){instr_imm[IMM_BITS-1]}}, instr_imm}
                                : rs2_value;
  assign alloc_b_ready = is_imm || rs2_ready;
  assign alloc_b_tag   = is_imm ? '0 : rs2_tag;

endmodule

// File: source/reservation_station.sv
`timescale 1ns/1ns

module reservation_station (
  input  logic                                 global_bus,
  input  logic                                 rst_n,
  input  ooo_pkg::unit_e                       station_id,
  input  logic                                 alloc,
  input  ooo_pkg::op_e                         alloc_op,
  input  logic [ooo_pkg::XLEN-1:0]             alloc_a,
  input  logic [ooo_pkg::XLEN-1:0]             alloc_b,
  input  logic                                 alloc_a_ready,
  input  logic                                 alloc_b_ready,
  input  logic [ooo_pkg::TAG_BITS-1:0]         alloc_a_tag,
  input  logic [ooo_pkg::TAG_BITS-1:0]         alloc_b_tag,
  output logic [ooo_pkg::INDEX_BITS-1:0]       free_index,
  output logic                                 credit_return,
  input  logic [1:0]                           cdb_valid,
  input  logic [1:0][ooo_pkg::TAG_BITS-1:0]    cdb_tag,
  input  logic [1:0][ooo_pkg::XLEN-1:0]        cdb_value,
  output logic                                 exec_valid,
  output ooo_pkg::op_e                         exec_op,
  output logic [ooo_pkg::XLEN-1:0]             exec_a,
  output logic [ooo_pkg::XLEN-1:0]             exec_b,
  output logic [ooo_pkg::TAG_BITS-1:0]         exec_tag
);
  import ooo_pkg::*;

  logic [STATION_SIZE-1:0] busy;
  logic [STATION_SIZE-1:0] issued;
  logic [STATION_SIZE-1:0] a_ready;
  logic [STATION_SIZE-1:0] b_ready;
  op_e                     op [STATION_SIZE];
  logic [XLEN-1:0]         a_value [STATION_SIZE];
  logic [XLEN-1:0]         b_value [STATION_SIZE];
  logic [TAG_BITS-1:0]     a_tag [STATION_SIZE];
  logic [TAG_BITS-1:0]     b_tag [STATION_SIZE];
  logic [INDEX_BITS-1:0]   pick;
  logic                    pick_valid;
  logic                    release_entry;
  logic [INDEX_BITS-1:0]   done_index;

  // An entry stays held until its own result is broadcast,
  // so its tag never names two instructions in flight.
  assign release_entry = cdb_valid[station_id];
  assign done_index    = cdb_tag[station_id][INDEX_BITS-1:0];

  always_comb begin
    free_index = '0;
    pick       = '0;
    pick_valid = 1'b0;
    for (int e = STATION_SIZE - 1; e >= 0; e--) begin   // lowest index wins.
      if (!busy[e]) begin
        free_index = INDEX_BITS'(e);
      end
      if (busy[e] && !issued[e] && a_ready[e] && b_ready[e]) begin
        pick       = INDEX_BITS'(e);
        pick_valid = 1'b1;
      end
    end
  end

  always_ff @(posedge global_bus or negedge rst_n) begin
    if (!rst_n) begin
      busy          <= '0;
      issued        <= '0;
      a_ready       <= '0;
      b_ready       <= '0;
      exec_valid    <= 1'b0;
      credit_return <= 1'b0;
    end else begin
      exec_valid    <= pick_valid;
      credit_return <= release_entry;
      for (int e = 0; e < STATION_SIZE; e++) begin
        for (int k = 0; k < 2; k++) begin
          if (busy[e] && !a_ready[e] && cdb_valid[k] && cdb_tag[k] == a_tag[e]) begin
            a_ready[e] <= 1'b1;
          end
          if (busy[e] && !b_ready[e] && cdb_valid[k] && cdb_tag[k] == b_tag[e]) begin
            b_ready[e] <= 1'b1;
          end
        end
      end
      if (pick_valid) begin
        issued[pick] <= 1'b1;
      end
      if (release_entry) begin
        busy[done_index]   <= 1'b0;
        issued[done_index] <= 1'b0;
      end
      if (alloc) begin
        busy[free_index]    <= 1'b1;
        a_ready[free_index] <= alloc_a_ready;
        b_ready[free_index] <= alloc_b_ready;
      end
    end
  end

  always_ff @(posedge global_bus) begin
    for (int e = 0; e < STATION_SIZE; e++) begin
      for (int k = 0; k < 2; k++) begin
        if (busy[e] && !a_ready[e] && cdb_valid[k] && cdb_tag[k] == a_tag[e]) begin
          a_value[e] <= cdb_value[k];
        end
        if (busy[e] && !b_ready[e] && cdb_valid[k] && cdb_tag[k] == b_tag[e]) begin
          b_value[e] <= cdb_value[k];
        end
      end
    end
    if (alloc) begin
      op[free_index]      <= alloc_op;
      a_value[free_index] <= alloc_a;
      b_value[free_index] <= alloc_b;
      a_tag[free_index]   <= alloc_a_tag;
      b_tag[free_index]   <= alloc_b_tag;
    end
    if (pick_valid) begin
      exec_op  <= op[pick];
      exec_a   <= a_value[pick];
      exec_b   <= b_value[pick];
      exec_tag <= {station_id, pick};
    end
  end

endmodule

// File: source/alu_unit.sv
`timescale 1ns/1ns

module alu_unit (
  input  logic                         global_bus,
  input  logic                         rst_n,
  input  logic                         exec_valid,
  input  ooo_pkg::op_e                 exec_op,
  input  logic [ooo_pkg::XLEN-1:0]     exec_a,
  input  logic [ooo_pkg::XLEN-1:0]     exec_b,
  input  logic [ooo_pkg::TAG_BITS-1:0] exec_tag,
  output logic                         cdb_valid,
  output logic [ooo_pkg::TAG_BITS-1:0] cdb_tag,
  output logic [ooo_pkg::XLEN-1:0]     cdb_value
);
  import ooo_pkg::*;

  logic [XLEN-1:0] result;

  always_comb begin
    case (exec_op)
      OP_SUB:  result = exec_a - exec_b;
      OP_AND:  result = exec_a & exec_b;
      OP_OR:   result = exec_a | exec_b;
      OP_XOR:  result = exec_a ^ exec_b;
      default: result = exec_a + exec_b;    // add and addi.
    endcase
  end

  always_ff @(posedge global_bus or negedge rst_n) begin
    if (!rst_n) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= exec_valid;
    end
  end

  always_ff @(posedge global_bus) begin
    cdb_tag   <= exec_tag;
    cdb_value <= result;
  end

endmodule

// File: source/mul_unit.sv
`timescale 1ns/1ns

module mul_unit (
  input  logic                         global_bus,
  input  logic                         rst_n,
  input  logic                         exec_valid,
  input  ooo_pkg::op_e                 exec_op,
  input  logic [ooo_pkg::XLEN-1:0]     exec_a,
  input  logic [ooo_pkg::XLEN-1:0]     exec_b,
  input  logic [ooo_pkg::TAG_BITS-1:0] exec_tag,
  output logic                         cdb_valid,
  output logic [ooo_pkg::TAG_BITS-1:0] cdb_tag,
  output logic [ooo_pkg::XLEN-1:0]     cdb_value
);
  import ooo_pkg::*;

  logic [MUL_LATENCY-1:0] valid_q;
  logic [TAG_BITS-1:0]    tag_q [MUL_LATENCY];
  logic [XLEN-1:0]        part_lo_q;
  logic [XLEN-1:0]        part_hi_q;
  logic [XLEN-1:0]        prod_q [MUL_LATENCY-1];

  always_ff @(posedge global_bus or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[MUL_LATENCY-2:0], exec_valid && exec_op == OP_MUL};
    end
  end

  always_ff @(posedge global_bus) begin
    tag_q[0]  <= exec_tag;
    part_lo_q <= exec_a * exec_b[XLEN/2-1:0];     // low half of b.
    part_hi_q <= exec_a * exec_b[XLEN-1:XLEN/2];  // high half, shifted later.
    prod_q[0] <= part_lo_q + (part_hi_q << (XLEN / 2));
    for (int s = 1; s < MUL_LATENCY; s++) begin
      tag_q[s] <= tag_q[s-1];
    end
    for (int s = 1; s < MUL_LATENCY - 1; s++) begin
      prod_q[s] <= prod_q[s-1];
    end
  end

  assign cdb_valid = valid_q[MUL_LATENCY-1];
  assign cdb_tag   = tag_q[MUL_LATENCY-1];
  assign cdb_value = prod_q[MUL_LATENCY-2];

endmodule

// File: source/ooo_core.sv
`timescale 1ns/1ns

module ooo_core (
  input  logic                              global_bus,
  input  logic                              rst_n,
  input  logic                              instr_valid,
  input  ooo_pkg::op_e                      instr_op,
  input  logic [ooo_pkg::REG_BITS-1:0]      instr_rd,
  input  logic [ooo_pkg::REG_BITS-1:0]      instr_rs1,
  input  logic [ooo_pkg::REG_BITS-1:0]      instr_rs2,
  input  logic [ooo_pkg::IMM_BITS-1:0]      instr_imm,
  output logic                              instr_ready,
  output logic                              idle,
  input  logic [ooo_pkg::REG_BITS-1:0]      reg_read_addr,
  output logic [ooo_pkg::XLEN-1:0]          reg_read_data,
  output logic [1:0]                        cdb_valid,
  output logic [1:0][ooo_pkg::TAG_BITS-1:0] cdb_tag,
  output logic [1:0][ooo_pkg::XLEN-1:0]     cdb_value
);
  import ooo_pkg::*;

  logic [REG_BITS-1:0]        rs1;
  logic [REG_BITS-1:0]        rs2;
  logic [XLEN-1:0]            rs1_value;
  logic [XLEN-1:0]            rs2_value;
  logic                       rs1_ready;
  logic                       rs2_ready;
  logic [TAG_BITS-1:0]        rs1_tag;
  logic [TAG_BITS-1:0]        rs2_tag;
  logic                       rename;
  logic [REG_BITS-1:0]        rename_rd;
  logic [TAG_BITS-1:0]        rename_tag;
  logic                       any_busy;
  logic [1:0][INDEX_BITS-1:0] free_index;
  logic [1:0]                 credit_return;
  logic [1:0]                 alloc;
  op_e                        alloc_op;
  logic [XLEN-1:0]            alloc_a;
  logic [XLEN-1:0]            alloc_b;
  logic                       alloc_a_ready;
  logic                       alloc_b_ready;
  logic [TAG_BITS-1:0]        alloc_a_tag;
  logic [TAG_BITS-1:0]        alloc_b_tag;
  logic [1:0]                 exec_valid;
  op_e                        exec_op [2];
  logic [1:0][XLEN-1:0]       exec_a;
  logic [1:0][XLEN-1:0]       exec_b;
  logic [1:0][TAG_BITS-1:0]   exec_tag;

  issue_unit issue_i (
    .global_bus, .rst_n,
    .instr_valid, .instr_op, .instr_rd, .instr_rs1, .instr_rs2, .instr_imm,
    .instr_ready, .idle, .any_busy,
    .rs1, .rs2, .rs1_value, .rs2_value, .rs1_ready, .rs2_ready, .rs1_tag, .rs2_tag,
    .rename, .rename_rd, .rename_tag,
    .free_index, .credit_return, .alloc,
    .alloc_op, .alloc_a, .alloc_b, .alloc_a_ready, .alloc_b_ready,
    .alloc_a_tag, .alloc_b_tag
  );

  register_status regs_i (
    .global_bus, .rst_n,
    .rs1, .rs2, .rs1_value, .rs2_value, .rs1_ready, .rs2_ready, .rs1_tag, .rs2_tag,
    .rename, .rename_rd, .rename_tag,
    .cdb_valid, .cdb_tag, .cdb_value,
    .reg_read_addr, .reg_read_data, .any_busy
  );

  for (genvar k = 0; k < 2; k++) begin : gen_station
    reservation_station station_i (
      .global_bus, .rst_n,
      .station_id    (unit_e'(k)),
      .alloc         (alloc[k]),
      .alloc_op, .alloc_a, .alloc_b, .alloc_a_ready, .alloc_b_ready,
      .alloc_a_tag, .alloc_b_tag,
      .free_index    (free_index[k]),
      .credit_return (credit_return[k]),
      .cdb_valid, .cdb_tag, .cdb_value,
      .exec_valid    (exec_valid[k]),
      .exec_op       (exec_op[k]),
      .exec_a        (exec_a[k]),
      .exec_b        (exec_b[k]),
      .exec_tag      (exec_tag[k])
    );
  end

  alu_unit alu_i (
    .global_bus, .rst_n,
    .exec_valid (exec_valid[UNIT_ALU]),
    .exec_op    (exec_op[UNIT_ALU]),
    .exec_a     (exec_a[UNIT_ALU]),
    .exec_b     (exec_b[UNIT_ALU]),
    .exec_tag   (exec_tag[UNIT_ALU]),
    .cdb_valid  (cdb_valid[UNIT_ALU]),
    .cdb_tag    (cdb_tag[UNIT_ALU]),
    .cdb_value  (cdb_value[UNIT_ALU])
  );

  mul_unit mul_i (
    .global_bus, .rst_n,
    .exec_valid (exec_valid[UNIT_MUL]),
    .exec_op    (exec_op[UNIT_MUL]),
    .exec_a     (exec_a[UNIT_MUL]),
    .exec_b     (exec_b[UNIT_MUL]),
    .exec_tag   (exec_tag[UNIT_MUL]),
    .cdb_valid  (cdb_valid[UNIT_MUL]),
    .cdb_tag    (cdb_tag[UNIT_MUL]),
    .cdb_value  (cdb_value[UNIT_MUL])
  );

endmodule

// File: verification/ooo_core_tb.sv
`timescale 1ns/1ns

module ooo_core_tb;
  import ooo_pkg::*;

  localparam int PHASE2_LEN = 60;
  localparam int PHASE3_LEN = 80;
  localparam int CHAIN_LEN = 24;
  localparam int TOTAL_INSTR = PHASE2_LEN + PHASE3_LEN + 2 + CHAIN_LEN;
  localparam int WATCHDOG_CYCLES = TOTAL_INSTR * (MUL_LATENCY + STATION_SIZE) + 200;
  localparam int DRAIN_LIMIT = 200;

  logic                 global_bus;
  logic                 rst_n;
  logic                 instr_valid;
  op_e                  instr_op;
  logic [REG_BITS-1:0]  instr_rd;
  logic [REG_BITS-1:0]  instr_rs1;
  logic [REG_BITS-1:0]  instr_rs2;
  logic [IMM_BITS-1:0]  instr_imm;
  logic                 instr_ready;
  logic                 idle;
  logic [REG_BITS-1:0]  reg_read_addr;
  logic [XLEN-1:0]      reg_read_data;
  logic [1:0]           cdb_valid;
  logic [1:0][TAG_BITS-1:0] cdb_tag;
  logic [1:0][XLEN-1:0] cdb_value;

  integer          seed = 1;
  logic [XLEN-1:0] model_regs [REG_COUNT];
  logic [XLEN-1:0] pending_alu [$];
  logic [XLEN-1:0] pending_mul [$];
  int              alu_count = 0;
  int              mul_count = 0;
  int              bus_pulses [2] = '{0, 0};
  int              stall_cycles = 0;
  int              value_errors = 0;
  int              count_errors = 0;
  int              flag_errors = 0;
  int              other_errors = 0;

  ooo_core dut_i (
    .global_bus, .rst_n,
    .instr_valid, .instr_op, .instr_rd, .instr_rs1, .instr_rs2, .instr_imm,
    .instr_ready, .idle, .reg_read_addr, .reg_read_data,
    .cdb_valid, .cdb_tag, .cdb_value
  );

  initial global_bus = 1'b0;
  always #50 global_bus = ~global_bus;

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge global_bus);
    $display("watchdog expired after %0d cycles, the DUT stopped making progress",
             WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  function automatic int rand_below(input int n);
    return int'({$random(seed)} % n);
  endfunction

  function automatic logic [XLEN-1:0] expected_result(input op_e op, input logic [XLEN-1:0] a,
                                                      input logic [XLEN-1:0] b,
                                                      input logic [IMM_BITS-1:0] imm);
    logic [2*XLEN-1:0] product;
    product = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_ADDI: return a + {{(XLEN - IMM_BITS){imm[IMM_BITS-1]}}, imm};
      default: return product[XLEN-1:0];   // low half only.
    endcase
  endfunction

  task automatic check_value(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      count_errors++;
      $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flag_errors++;
      $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
  endtask

  // a broadcast must carry the result of some accepted instruction.
  task automatic retire_result(input int k, input logic [XLEN-1:0] value);
    int hit;
    hit = -1;
    if (k == 0) begin
      for (int i = 0; i < pending_alu.size(); i++) begin
        if (hit < 0 && pending_alu[i] === value) hit = i;
      end
      if (hit >= 0) pending_alu.delete(hit);
    end else begin
      for (int i = 0; i < pending_mul.size(); i++) begin
        if (hit < 0 && pending_mul[i] === value) hit = i;
      end
      if (hit >= 0) pending_mul.delete(hit);
    end
    if (hit < 0) begin
      value_errors++;
      $display("[ERROR] cdb_value[%0d] got %h, no pending result expects it", k, value);
    end
  endtask

  always @(negedge global_bus) begin   // bus outputs settle mid-cycle.
    if (rst_n) begin
      for (int k = 0; k < 2; k++) begin
        if (cdb_valid[k]) begin
          bus_pulses[k]++;
          check_flag($sformatf("cdb_tag[%0d] station bit", k), cdb_tag[k][TAG_BITS-1], k[0]);
          retire_result(k, cdb_value[k]);
        end
      end
    end
  end

  // holds the instruction until instr_ready, then updates the model.
  task automatic send(input op_e op, input int rd, input int rs1, input int rs2,
                      input logic [IMM_BITS-1:0] imm);
    @(negedge global_bus);
    instr_valid = 1'b1;
    instr_op    = op;
    instr_rd    = rd[REG_BITS-1:0];
    instr_rs1   = rs1[REG_BITS-1:0];
    instr_rs2   = rs2[REG_BITS-1:0];
    instr_imm   = imm;
    #1;
    while (!instr_ready) begin
      stall_cycles++;
      @(negedge global_bus);
      #1;
    end
    model_regs[rd] = expected_result(op, model_regs[rs1], model_regs[rs2], imm);
    if (op == OP_MUL) begin
      mul_count++;
      pending_mul.push_back(model_regs[rd]);
    end else begin
      alu_count++;
      pending_alu.push_back(model_regs[rd]);
    end
  endtask

  task automatic send_random(input int reg_span, input bit with_mul);
    op_e op;
    int  rd;
    int  rs1;
    int  rs2;
    op = op_e'(rand_below(6));
    if (with_mul && rand_below(3) == 0) op = OP_MUL;
    rd  = rand_below(reg_span);
    rs1 = rand_below(reg_span);
    rs2 = rand_below(reg_span);
    send(op, rd, rs1, rs2, IMM_BITS'(rand_below(65536)));
  endtask

  task automatic drain();
    int cycles;
    cycles = 0;
    @(negedge global_bus);
    instr_valid = 1'b0;
    #1;
    while (!idle && cycles < DRAIN_LIMIT) begin
      @(negedge global_bus);
      #1;
      cycles++;
    end
    if (!idle) begin
      other_errors++;
      $display("idle never rose within %0d cycles after the stream ended", DRAIN_LIMIT);
    end
    repeat (MUL_LATENCY) @(negedge global_bus);
  endtask

  task automatic compare_registers();
    for (int r = 0; r < REG_COUNT; r++) begin
      @(negedge global_bus);
      reg_read_addr = r[REG_BITS-1:0];
      #1;
      check_value($sformatf("reg_read_data r%0d", r), reg_read_data, model_regs[r]);
    end
  endtask

  initial begin
    rst_n         = 1'b0;
    instr_valid   = 1'b0;
    instr_op      = OP_ADD;
    instr_rd      = '0;
    instr_rs1     = '0;
    instr_rs2     = '0;
    instr_imm     = '0;
    reg_read_addr = '0;
    for (int r = 0; r < REG_COUNT; r++) model_regs[r] = '0;
    repeat (5) @(negedge global_bus);
    rst_n = 1'b1;

    #1;
    check_flag("instr_ready", instr_ready, 1'b1);
    check_flag("idle", idle, 1'b1);
    compare_registers();

    for (int i = 0; i < PHASE2_LEN; i++) send_random(REG_COUNT, 1'b0);
    drain();
    compare_registers();

    for (int i = 0; i < PHASE3_LEN; i++) send_random(4, 1'b1);   // dense reuse.
    drain();
    compare_registers();

    send(OP_ADDI, 5, 0, 0, 16'h0003);
    send(OP_ADDI, 6, 1, 0, 16'hfff7);
    stall_cycles = 0;
    for (int i = 0; i < CHAIN_LEN; i++) send(OP_MUL, 5, 5, 6, '0);   // serial chain.
    if (stall_cycles == 0) begin
      other_errors++;
      $display("instr_ready never dropped while the multiply chain was offered");
    end
    drain();
    compare_registers();

    check_count("cdb_valid[0] pulses", bus_pulses[0], alu_count);
    check_count("cdb_valid[1] pulses", bus_pulses[1], mul_count);

    $display("errors: value %0d, count %0d, flag %0d, other %0d",
             value_errors, count_errors, flag_errors, other_errors);
    if (value_errors + count_errors + flag_errors + other_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: ooo_core.f
source/ooo_pkg.sv
source/register_status.sv
source/issue_unit.sv
source/reservation_station.sv
source/alu_unit.sv
source/mul_unit.sv
source/ooo_core.sv
verification/ooo_core_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f ooo_core.f --top-module ooo_core_tb -o ooo_core_sim

out=$(./obj_dir/ooo_core_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Test completed successfully"; then
  exit 0
else
  exit 1
fi
